// File: prf.f
+incdir+rtl
rtl/prf_pkg.sv
rtl/prf_port_if.sv
rtl/prf_value_bank.sv
rtl/prf_ready_table.sv
rtl/prf_operand_mux.sv
rtl/prf.sv
verification/prf_sva.sv
verification/prf_tb.sv

// File: Bender.yml
package:
  name: prf

sources:
  # design
  - include_dirs:
      - rtl
    files:
      - rtl/prf_pkg.sv
      - rtl/prf_port_if.sv
      - rtl/prf_value_bank.sv
      - rtl/prf_ready_table.sv
      - rtl/prf_operand_mux.sv
      - rtl/prf.sv

  # verification
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/prf_sva.sv
      - verification/prf_tb.sv

// File: verification/prf_tb.sv
`timescale 1ns/1ns

`include "prf_config.svh"

module prf_tb;

    // ======================================================================
    // run length
    // ======================================================================

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RAND_CYCLES     = 3000;
    localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES;
    // random tags squeezed into 16 registers, lots of collisions
    localparam logic [31:0] TAG_MASK = 32'h0000_000f;

    logic                          clk;
    logic                          reset_i;
    prf_pkg::prf_tag_t             rd_tag_i      [`PRF_RD_PORT_NUM];
    logic [`PRF_BC_NUM-1:0]        bc_valid_i;
    prf_pkg::prf_tag_t             bc_tag_i      [`PRF_BC_NUM];
    prf_pkg::prf_word_t            bc_value_i    [`PRF_BC_NUM];
    logic [`PRF_ALLOC_NUM-1:0]     alloc_valid_i;
    prf_pkg::prf_tag_t             alloc_tag_i   [`PRF_ALLOC_NUM];
    prf_pkg::prf_word_t            rd_value_o    [`PRF_RD_PORT_NUM];
    logic [`PRF_RD_PORT_NUM-1:0]   rd_ready_o;

    // reference state and per-port prediction
    prf_pkg::prf_word_t            mdl_value     [`PRF_PHY_REG_NUM];
    logic                          mdl_ready     [`PRF_PHY_REG_NUM];
    prf_pkg::prf_word_t            exp_value     [`PRF_RD_PORT_NUM];
    logic                          exp_ready     [`PRF_RD_PORT_NUM];

    integer seed;

    prf prf_i (
        .clk_i         (clk),
        .reset_i       (reset_i),
        .rd_tag_i      (rd_tag_i),
        .bc_valid_i    (bc_valid_i),
        .bc_tag_i      (bc_tag_i),
        .bc_value_i    (bc_value_i),
        .alloc_valid_i (alloc_valid_i),
        .alloc_tag_i   (alloc_tag_i),
        .rd_value_o    (rd_value_o),
        .rd_ready_o    (rd_ready_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_values(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // ======================================================================
    // reference model
    // ======================================================================

    // updates land at the edge, the registered read shows the state after it
    always @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < `PRF_PHY_REG_NUM; r++) begin
                mdl_value[r] = '0;
                mdl_ready[r] = 1'b1;
            end
            for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
                exp_value[p] = '0;
                exp_ready[p] = 1'b0;
            end
        end else begin
            // write-back, later channel overwrites an earlier one
            for (int ch = 0; ch < `PRF_BC_NUM; ch++) begin
                if (bc_valid_i[ch]) begin
                    mdl_value[bc_tag_i[ch]] = bc_value_i[ch];
                    mdl_ready[bc_tag_i[ch]] = 1'b1;
                end
            end
            // allocation last, wins the ready bit
            for (int a = 0; a < `PRF_ALLOC_NUM; a++) begin
                if (alloc_valid_i[a]) begin
                    mdl_ready[alloc_tag_i[a]] = 1'b0;
                end
            end
            for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
                exp_value[p] = mdl_value[rd_tag_i[p]];
                exp_ready[p] = mdl_ready[rd_tag_i[p]];
            end
        end
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
            compare_values($sformatf("rd_value_o[%0d]", p), rd_value_o[p], exp_value[p]);
            compare_values($sformatf("rd_ready_o[%0d]", p), rd_ready_o[p], exp_ready[p]);
        end
    end

    // ======================================================================
    // stimulus helpers
    // ======================================================================

    task automatic next_cycle();
        @(posedge clk);
        bc_valid_i    <= '0;
        alloc_valid_i <= '0;
    endtask

    task automatic set_read(input int p, input prf_pkg::prf_tag_t tag);
        rd_tag_i[p] <= tag;
    endtask

    task automatic set_bc(input int ch, input prf_pkg::prf_tag_t tag,
                          input prf_pkg::prf_word_t value);
        bc_valid_i[ch] <= 1'b1;
        bc_tag_i[ch]   <= tag;
        bc_value_i[ch] <= value;
    endtask

    task automatic set_alloc(input int a, input prf_pkg::prf_tag_t tag);
        alloc_valid_i[a] <= 1'b1;
        alloc_tag_i[a]   <= tag;
    endtask

    // fixed expectation for a directed read, call after the negedge
    task automatic expect_read(input int p, input prf_pkg::prf_word_t value, input logic ready);
        compare_values($sformatf("rd_value_o[%0d]", p), rd_value_o[p], value);
        compare_values($sformatf("rd_ready_o[%0d]", p), rd_ready_o[p], ready);
    endtask

    task automatic random_stimulus();
        logic [31:0] rnd;
        for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
            rnd = $random(seed);
            rd_tag_i[p] <= prf_pkg::prf_tag_t'(rnd & TAG_MASK);
        end
        for (int ch = 0; ch < `PRF_BC_NUM; ch++) begin
            rnd = $random(seed);
            bc_valid_i[ch] <= rnd[8];
            bc_tag_i[ch]   <= prf_pkg::prf_tag_t'(rnd & TAG_MASK);
            bc_value_i[ch] <= $random(seed);
        end
        // allocation about one lane in four
        for (int a = 0; a < `PRF_ALLOC_NUM; a++) begin
            rnd = $random(seed);
            alloc_valid_i[a] <= (rnd[9:8] == 2'b00);
            alloc_tag_i[a]   <= prf_pkg::prf_tag_t'(rnd & TAG_MASK);
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        seed          = 32'habf3_71f8;
        clk           = 1'b0;
        reset_i       = 1'b1;
        bc_valid_i    = '0;
        alloc_valid_i = '0;
        for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
            rd_tag_i[p] = prf_pkg::prf_tag_t'(p);
        end
        for (int ch = 0; ch < `PRF_BC_NUM; ch++) begin
            bc_tag_i[ch]   = '0;
            bc_value_i[ch] = '0;
        end
        for (int a = 0; a < `PRF_ALLOC_NUM; a++) begin
            alloc_tag_i[a] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        // fresh file reads zero and ready
        set_read(0, 6'd5);
        set_read(1, 6'd63);
        next_cycle();
        @(negedge clk);
        expect_read(0, '0, 1'b1);
        expect_read(1, '0, 1'b1);

        // write-back then a later read
        next_cycle();
        set_bc(0, 6'd10, 32'h1234_5678);
        next_cycle();
        next_cycle();
        set_read(0, 6'd10);
        next_cycle();
        @(negedge clk);
        expect_read(0, 32'h1234_5678, 1'b1);

        // allocation drops ready, keeps the old value
        next_cycle();
        set_alloc(0, 6'd10);
        next_cycle();
        next_cycle();
        @(negedge clk);
        expect_read(0, 32'h1234_5678, 1'b0);

        // same-edge forwarding, channel 1 beats channel 0
        next_cycle();
        set_read(2, 6'd20);
        set_bc(0, 6'd20, 32'haaaa_0001);
        set_bc(1, 6'd20, 32'hbbbb_0002);
        next_cycle();
        @(negedge clk);
        expect_read(2, 32'hbbbb_0002, 1'b1);

        // allocation and broadcast on one edge
        next_cycle();
        set_read(3, 6'd30);
        set_alloc(1, 6'd30);
        set_bc(0, 6'd30, 32'hcccc_0003);
        next_cycle();
        @(negedge clk);
        expect_read(3, 32'hcccc_0003, 1'b0);
        next_cycle();
        next_cycle();
        @(negedge clk);
        expect_read(2, 32'hbbbb_0002, 1'b1);
        expect_read(3, 32'hcccc_0003, 1'b0);

        // long random mix, model checks every cycle
        for (int i = 0; i < RAND_CYCLES; i++) begin
            next_cycle();
            random_stimulus();
        end
        next_cycle();
        next_cycle();
        @(negedge clk);
        #1;
        $display("TEST RESULT: PASS");
        $finish;
    end

    // bound on total run time
    initial begin
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation timeout");
    end

endmodule

// File: verification/prf_sva.sv
`timescale 1ns/1ns

`include "prf_config.svh"

// ==========================================================================
// concurrent checks on the register file top level
// ==========================================================================

module prf_sva (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  prf_pkg::prf_tag_t             rd_tag_i    [`PRF_RD_PORT_NUM],
    input  logic [`PRF_BC_NUM-1:0]        bc_valid_i,
    input  prf_pkg::prf_tag_t             bc_tag_i    [`PRF_BC_NUM],
    input  logic [`PRF_ALLOC_NUM-1:0]     alloc_valid_i,
    input  prf_pkg::prf_tag_t             alloc_tag_i [`PRF_ALLOC_NUM],
    input  prf_pkg::prf_word_t            rd_value_o  [`PRF_RD_PORT_NUM],
    input  logic [`PRF_RD_PORT_NUM-1:0]   rd_ready_o
);

    // per port, does this edge carry a broadcast or an allocation of the read tag
    logic [`PRF_RD_PORT_NUM-1:0] bc_hit;
    logic [`PRF_RD_PORT_NUM-1:0] alloc_hit;

    always_comb begin
        bc_hit    = '0;
        alloc_hit = '0;
        for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
            for (int ch = 0; ch < `PRF_BC_NUM; ch++) begin
                if (bc_valid_i[ch] && (bc_tag_i[ch] == rd_tag_i[p])) begin
                    bc_hit[p] = 1'b1;
                end
            end
            for (int a = 0; a < `PRF_ALLOC_NUM; a++) begin
                if (alloc_valid_i[a] && (alloc_tag_i[a] == rd_tag_i[p])) begin
                    alloc_hit[p] = 1'b1;
                end
            end
        end
    end

    // registered ready stays idle through reset
    ready_low_in_reset: assert property (@(posedge clk_i) reset_i |=> (rd_ready_o == '0))
        else $error("rd_ready_o not cleared by reset");

    for (genvar p = 0; p < `PRF_RD_PORT_NUM; p++) begin : g_port
        // no X or Z once out of reset
        outputs_known: assert property (@(posedge clk_i) disable iff (reset_i)
            !$isunknown({rd_value_o[p], rd_ready_o[p]}))
            else $error("unknown operand output on port %0d", p);

        // same-edge broadcast makes the operand ready, unless reallocated
        forward_ready: assert property (@(posedge clk_i) disable iff (reset_i)
            (bc_hit[p] && !alloc_hit[p]) |=> rd_ready_o[p])
            else $error("forwarded operand not ready on port %0d", p);
    end

endmodule

bind prf prf_sva sva_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rd_tag_i      (rd_tag_i),
    .bc_valid_i    (bc_valid_i),
    .bc_tag_i      (bc_tag_i),
    .alloc_valid_i (alloc_valid_i),
    .alloc_tag_i   (alloc_tag_i),
    .rd_value_o    (rd_value_o),
    .rd_ready_o    (rd_ready_o)
);

// File: rtl/prf.sv
`timescale 1ns/1ns

`include "prf_config.svh"

// ==========================================================================
// physical register file, top level
// ==========================================================================

module prf (
    input  logic                          clk_i,
    input  logic                          reset_i,
    // operand read ports, from reservation stations
    input  prf_pkg::prf_tag_t             rd_tag_i      [`PRF_RD_PORT_NUM],
    // common data bus write-back
    input  logic [`PRF_BC_NUM-1:0]        bc_valid_i,
    input  prf_pkg::prf_tag_t             bc_tag_i      [`PRF_BC_NUM],
    input  prf_pkg::prf_word_t            bc_value_i    [`PRF_BC_NUM],
    // dispatch allocation lanes
    input  logic [`PRF_ALLOC_NUM-1:0]     alloc_valid_i,
    input  prf_pkg::prf_tag_t             alloc_tag_i   [`PRF_ALLOC_NUM],
    // operand results, one cycle after the tag
    output prf_pkg::prf_word_t            rd_value_o    [`PRF_RD_PORT_NUM],
    output logic [`PRF_RD_PORT_NUM-1:0]   rd_ready_o
);

    // shared bundle between the three parts
    prf_port_if port_if ();

    // ----------------------------------------------------------------------
    // drive bundle from top ports
    // ----------------------------------------------------------------------

    assign port_if.rd_tag   = rd_tag_i;
    assign port_if.bc_valid = bc_valid_i;
    assign port_if.bc_tag   = bc_tag_i;
    assign port_if.bc_value = bc_value_i;

    // ----------------------------------------------------------------------
    // storage, both parts read in parallel
    // ----------------------------------------------------------------------

    prf_value_bank value_bank_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .port_if (port_if)
    );

    // allocation lanes go to the table only
    prf_ready_table ready_table_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alloc_valid_i (alloc_valid_i),
        .alloc_tag_i   (alloc_tag_i),
        .port_if       (port_if)
    );

    // ----------------------------------------------------------------------
    // combine, forward, register
    // ----------------------------------------------------------------------

    prf_operand_mux operand_mux_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alloc_valid_i (alloc_valid_i),
        .alloc_tag_i   (alloc_tag_i),
        .port_if       (port_if),
        .rd_value_o    (rd_value_o),
        .rd_ready_o    (rd_ready_o)
    );

endmodule

// File: rtl/prf_operand_mux.sv
`timescale 1ns/1ns

`include "prf_config.svh"

// ==========================================================================
// operand combiner: bank value + ready bit + same-edge forwarding
// ==========================================================================

module prf_operand_mux (
    input  logic                          clk_i,
    input  logic                          reset_i,
    // allocations also have to win on the forwarding path
    input  logic [`PRF_ALLOC_NUM-1:0]     alloc_valid_i,
    input  prf_pkg::prf_tag_t             alloc_tag_i [`PRF_ALLOC_NUM],
    prf_port_if.combiner                  port_if,
    // registered operand results
    output prf_pkg::prf_word_t            rd_value_o  [`PRF_RD_PORT_NUM],
    output logic [`PRF_RD_PORT_NUM-1:0]   rd_ready_o
);

    // forwarded result, before the register stage
    prf_pkg::prf_word_t                fwd_value [`PRF_RD_PORT_NUM];
    logic      [`PRF_RD_PORT_NUM-1:0]  fwd_ready;

    // ----------------------------------------------------------------------
    // forwarding
    // ----------------------------------------------------------------------

    always_comb begin
        for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
            // default is the stored state
            fwd_value[p] = port_if.bank_value[p];
            fwd_ready[p] = port_if.tbl_ready[p];

            // broadcast hit on this edge
            // ascending scan, highest matching channel ends up selected
            for (int ch = 0; ch < `PRF_BC_NUM; ch++) begin
                if (port_if.bc_valid[ch] && (port_if.bc_tag[ch] == port_if.rd_tag[p])) begin
                    fwd_value[p] = port_if.bc_value[ch];
                    fwd_ready[p] = 1'b1;
                end
            end

            // tag being reallocated right now
            // value stays, only ready drops
            for (int a = 0; a < `PRF_ALLOC_NUM; a++) begin
                if (alloc_valid_i[a] && (alloc_tag_i[a] == port_if.rd_tag[p])) begin
                    fwd_ready[p] = 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // output stage, fixed one-cycle latency
    // ----------------------------------------------------------------------

    // one read per port per cycle, no stall
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // outputs idle during reset
            for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
                rd_value_o[p] <= '0;
            end
            rd_ready_o <= '0;
        end else begin
            for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
                rd_value_o[p] <= fwd_value[p];
            end
            rd_ready_o <= fwd_ready;
        end
    end

endmodule

// File: rtl/prf_ready_table.sv
`timescale 1ns/1ns

`include "prf_config.svh"

// ==========================================================================
// ready table: one valid bit per physical register
// ==========================================================================

module prf_ready_table (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // dispatch allocation lanes
    input  logic [`PRF_ALLOC_NUM-1:0]   alloc_valid_i,
    input  prf_pkg::prf_tag_t           alloc_tag_i [`PRF_ALLOC_NUM],
    prf_port_if.tbl                     port_if
);

    // bit r high means register r holds a produced value
    logic [`PRF_PHY_REG_NUM-1:0] ready_q;
    logic [`PRF_PHY_REG_NUM-1:0] ready_d;

    // ----------------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------------

    always_comb begin
        ready_d = ready_q;
        // completed results become ready
        for (int ch = 0; ch < `PRF_BC_NUM; ch++) begin
            if (port_if.bc_valid[ch]) begin
                ready_d[port_if.bc_tag[ch]] = 1'b1;
            end
        end
        // clear pass comes last, allocation beats broadcast
        for (int a = 0; a < `PRF_ALLOC_NUM; a++) begin
            if (alloc_valid_i[a]) begin
                ready_d[alloc_tag_i[a]] = 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // state
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // nothing in flight after reset, all ready
            ready_q <= '1;
        end else begin
            ready_q <= ready_d;
        end
    end

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------

    // pre-edge bit, forwarding handled downstream
    always_comb begin
        for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
            port_if.tbl_ready[p] = ready_q[port_if.rd_tag[p]];
        end
    end

endmodule

// File: rtl/prf_value_bank.sv
`timescale 1ns/1ns

`include "prf_config.svh"

// ==========================================================================
// value bank: data words indexed by physical tag
// ==========================================================================

module prf_value_bank (
    input  logic       clk_i,
    input  logic       reset_i,
    prf_port_if.bank   port_if
);

    // storage array, one word per physical register
    prf_pkg::prf_word_t mem [`PRF_PHY_REG_NUM];

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------

    // channels walked in ascending order
    // so a later (higher) channel overrides an earlier one on the same tag
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // every register reads back zero after reset
            for (int r = 0; r < `PRF_PHY_REG_NUM; r++) begin
                mem[r] <= '0;
            end
        end else begin
            for (int ch = 0; ch < `PRF_BC_NUM; ch++) begin
                if (port_if.bc_valid[ch]) begin
                    mem[port_if.bc_tag[ch]] <= port_if.bc_value[ch];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------

    // zero latency, shows state before the edge
    // same-edge writes are the combiner's job
    always_comb begin
        for (int p = 0; p < `PRF_RD_PORT_NUM; p++) begin
            port_if.bank_value[p] = mem[port_if.rd_tag[p]];
        end
    end

endmodule

// File: rtl/prf_port_if.sv
`timescale 1ns/1ns

`include "prf_config.svh"

// ==========================================================================
// internal bundle between bank, ready table and operand combiner
// ==========================================================================

interface prf_port_if;

    // read side, one entry per operand port
    prf_pkg::prf_tag_t                 rd_tag     [`PRF_RD_PORT_NUM];

    // common data bus, one entry per channel
    logic      [`PRF_BC_NUM-1:0]       bc_valid;
    prf_pkg::prf_tag_t                 bc_tag     [`PRF_BC_NUM];
    prf_pkg::prf_word_t                bc_value   [`PRF_BC_NUM];

    // per-part read results, pre-edge state
    prf_pkg::prf_word_t                bank_value [`PRF_RD_PORT_NUM];
    logic      [`PRF_RD_PORT_NUM-1:0]  tbl_ready;

    // value bank side
    modport bank (
        input  rd_tag, bc_valid, bc_tag, bc_value,
        output bank_value
    );

    // ready table side
    modport tbl (
        input  rd_tag, bc_valid, bc_tag,
        output tbl_ready
    );

    // combiner only listens
    modport combiner (
        input  rd_tag, bc_valid, bc_tag, bc_value, bank_value, tbl_ready
    );

endinterface

// File: rtl/prf_pkg.sv
`include "prf_config.svh"

// ==========================================================================
// shared types for the register file
// ==========================================================================

package prf_pkg;

    // physical register tag
    // indexes both the value bank and the ready table
    typedef logic [`PRF_TAG_WIDTH-1:0] prf_tag_t;

    // one data word
    // as written back on the common data bus
    typedef logic [`PRF_XLEN-1:0] prf_word_t;

endpackage

// File: rtl/prf_config.svh
`ifndef PRF_CONFIG_SVH
`define PRF_CONFIG_SVH

// ==========================================================================
// physical register file sizing
// ==========================================================================

// physical registers, tag must cover all of them
`define PRF_PHY_REG_NUM 64
`define PRF_TAG_WIDTH   6

// data word width
`define PRF_XLEN        32

// two issue channels x two operands
`define PRF_RD_PORT_NUM 4

// common data bus channels
`define PRF_BC_NUM      2

// one lane per dispatch slot
`define PRF_ALLOC_NUM   4

`endif
